// ==== hw/rv_core.sv ====
`timescale 1ns/1ps

module rv_core
  import rv_isa_pkg::*;
  import rv_core_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  output word_t imem_addr,
  input  word_t imem_data,
  output word_t dmem_addr,
  input  word_t dmem_rdata,
  output logic  dmem_we,
  output word_t dmem_wdata,
  output strb_t dmem_wstrb,
  output logic  ebreak
);

  word_t      pc;
  word_t      next_pc;
  word_t      pc_plus4;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  reg_addr_t  rd;
  logic       reg_write;
  logic       mem_write;
  logic       alu_b_imm;
  logic       is_branch;
  logic       is_jump;
  logic       is_jalr;
  logic       is_ebreak;
  alu_a_sel_t alu_a_sel;
  alu_op_t    alu_op;
  res_sel_t   res_sel;
  logic [2:0] funct3;
  word_t      imm;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      alu_result;
  word_t      rd_data;
  logic       rf_we;

  // --------------------
  // Program counter
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else begin
      pc <= next_pc;
    end
  end

  assign imem_addr = pc;

  // No writes of any kind while in reset
  assign rf_we   = reg_write && !reset;
  assign dmem_we = mem_write && !reset;
  assign ebreak  = is_ebreak && !reset;

  rv_decode u_decode (
    .instr     (imem_data),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .reg_write (reg_write),
    .mem_write (mem_write),
    .alu_b_imm (alu_b_imm),
    .is_branch (is_branch),
    .is_jump   (is_jump),
    .is_jalr   (is_jalr),
    .is_ebreak (is_ebreak),
    .alu_a_sel (alu_a_sel),
    .alu_op    (alu_op),
    .res_sel   (res_sel),
    .funct3    (funct3),
    .imm       (imm)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rs1_addr (rs1),
    .rs2_addr (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rf_we),
    .rd_addr  (rd),
    .rd_data  (rd_data)
  );

  rv_execute u_execute (
    .pc         (pc),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .imm        (imm),
    .alu_a_sel  (alu_a_sel),
    .alu_op     (alu_op),
    .alu_b_imm  (alu_b_imm),
    .is_branch  (is_branch),
    .is_jump    (is_jump),
    .is_jalr    (is_jalr),
    .funct3     (funct3),
    .alu_result (alu_result),
    .next_pc    (next_pc),
    .pc_plus4   (pc_plus4)
  );

  rv_result u_result (
    .alu_result (alu_result),
    .rs2_data   (rs2_data),
    .dmem_rdata (dmem_rdata),
    .funct3     (funct3),
    .mem_write  (mem_write),
    .res_sel    (res_sel),
    .pc_plus4   (pc_plus4),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .rd_data    (rd_data)
  );

endmodule

// ==== hw/rv_core_pkg.sv ====
package rv_core_pkg;

  // --------------------
  // ALU operations
  typedef logic [3:0] alu_op_t;

  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_SLL    = 4'd2;
  localparam alu_op_t ALU_SLT    = 4'd3;
  localparam alu_op_t ALU_SLTU   = 4'd4;
  localparam alu_op_t ALU_XOR    = 4'd5;
  localparam alu_op_t ALU_SRL    = 4'd6;
  localparam alu_op_t ALU_SRA    = 4'd7;
  localparam alu_op_t ALU_OR     = 4'd8;
  localparam alu_op_t ALU_AND    = 4'd9;
  localparam alu_op_t ALU_PASS_B = 4'd10;

  // ALU A operand source
  typedef logic [1:0] alu_a_sel_t;

  localparam alu_a_sel_t A_RS1  = 2'd0;
  localparam alu_a_sel_t A_ZERO = 2'd1;
  localparam alu_a_sel_t A_PC   = 2'd2;

  // Write-back source
  typedef logic [1:0] res_sel_t;

  localparam res_sel_t RES_ALU  = 2'd0;
  localparam res_sel_t RES_LOAD = 2'd1;
  localparam res_sel_t RES_PC4  = 2'd2;

endpackage

// ==== hw/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode
  import rv_isa_pkg::*;
  import rv_core_pkg::*;
(
  input  instr_t     instr,
  output reg_addr_t  rs1,
  output reg_addr_t  rs2,
  output reg_addr_t  rd,
  output logic       reg_write,
  output logic       mem_write,
  output logic       alu_b_imm,
  output logic       is_branch,
  output logic       is_jump,
  output logic       is_jalr,
  output logic       is_ebreak,
  output alu_a_sel_t alu_a_sel,
  output alu_op_t    alu_op,
  output res_sel_t   res_sel,
  output logic [2:0] funct3,
  output word_t      imm
);

  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;

  // Shared by register and immediate forms
  function automatic alu_op_t alu_from_f3(input logic [2:0] f3, input logic alt);
    alu_op_t op;
    case (f3)
      F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:  op = ALU_SLL;
      F3_SLT:  op = ALU_SLT;
      F3_SLTU: op = ALU_SLTU;
      F3_XOR:  op = ALU_XOR;
      F3_SRL:  op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:   op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  // Register fields sit at the same bits in every format
  assign rs1    = instr.r.rs1;
  assign rs2    = instr.r.rs2;
  assign rd     = instr.r.rd;
  assign funct3 = instr.r.funct3;

  // --------------------
  // Immediates
  assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
  assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
  assign imm_b = {{19{instr.s.imm_hi[6]}}, instr.s.imm_hi[6], instr.s.imm_lo[0],
                  instr.s.imm_hi[5:0], instr.s.imm_lo[4:1], 1'b0};
  assign imm_u = {instr.u.imm, 12'b0};
  assign imm_j = {{11{instr.u.imm[19]}}, instr.u.imm[19], instr.u.imm[7:0],
                  instr.u.imm[8], instr.u.imm[18:9], 1'b0};

  // --------------------
  // Control
  always_comb begin
    reg_write = 1'b0;
    mem_write = 1'b0;
    alu_b_imm = 1'b0;
    is_branch = 1'b0;
    is_jump   = 1'b0;
    is_jalr   = 1'b0;
    is_ebreak = 1'b0;
    alu_a_sel = A_RS1;
    alu_op    = ALU_ADD;
    res_sel   = RES_ALU;
    imm       = imm_i;

    case (instr.r.opcode)
      OP_LUI: begin
        reg_write = 1'b1;
        alu_b_imm = 1'b1;
        alu_a_sel = A_ZERO;
        alu_op    = ALU_PASS_B;
        imm       = imm_u;
      end
      OP_AUIPC: begin
        reg_write = 1'b1;
        alu_b_imm = 1'b1;
        alu_a_sel = A_PC;
        imm       = imm_u;
      end
      OP_JAL: begin
        reg_write = 1'b1;
        is_jump   = 1'b1;
        res_sel   = RES_PC4;
        imm       = imm_j;
      end
      OP_JALR: begin
        reg_write = 1'b1;
        is_jump   = 1'b1;
        is_jalr   = 1'b1;
        alu_b_imm = 1'b1;
        res_sel   = RES_PC4;
      end
      OP_BRANCH: begin
        is_branch = 1'b1;
        imm       = imm_b;
      end
      OP_LOAD: begin
        reg_write = 1'b1;
        alu_b_imm = 1'b1;
        res_sel   = RES_LOAD;
      end
      OP_STORE: begin
        mem_write = 1'b1;
        alu_b_imm = 1'b1;
        imm       = imm_s;
      end
      OP_IMM: begin
        reg_write = 1'b1;
        alu_b_imm = 1'b1;
        // Only SRAI uses the alternate bit, ADDI has no subtract form
        alu_op    = alu_from_f3(instr.i.funct3,
                                instr.i.imm[10] && (instr.i.funct3 == F3_SRL));
      end
      OP_REG: begin
        reg_write = 1'b1;
        alu_op    = alu_from_f3(instr.r.funct3, instr.r.funct7[5]);
      end
      OP_SYSTEM: begin
        is_ebreak = (instr == I_EBREAK);
      end
      default: begin
        reg_write = 1'b0;
      end
    endcase
  end

endmodule

// ==== hw/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute
  import rv_isa_pkg::*;
  import rv_core_pkg::*;
(
  input  word_t      pc,
  input  word_t      rs1_data,
  input  word_t      rs2_data,
  input  word_t      imm,
  input  alu_a_sel_t alu_a_sel,
  input  alu_op_t    alu_op,
  input  logic       alu_b_imm,
  input  logic       is_branch,
  input  logic       is_jump,
  input  logic       is_jalr,
  input  logic [2:0] funct3,
  output word_t      alu_result,
  output word_t      next_pc,
  output word_t      pc_plus4
);

  word_t      alu_a;
  word_t      alu_b;
  word_t      target;
  logic [4:0] shamt;
  logic       taken;

  // --------------------
  // ALU
  always_comb begin
    case (alu_a_sel)
      A_PC:    alu_a = pc;
      A_ZERO:  alu_a = '0;
      default: alu_a = rs1_data;
    endcase
  end

  assign alu_b = alu_b_imm ? imm : rs2_data;
  assign shamt = alu_b[4:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:    alu_result = alu_a + alu_b;
      ALU_SUB:    alu_result = alu_a - alu_b;
      ALU_SLL:    alu_result = alu_a << shamt;
      ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
      ALU_SLTU:   alu_result = {{(XLEN-1){1'b0}}, alu_a < alu_b};
      ALU_XOR:    alu_result = alu_a ^ alu_b;
      ALU_SRL:    alu_result = alu_a >> shamt;
      ALU_SRA:    alu_result = $signed(alu_a) >>> shamt;
      ALU_OR:     alu_result = alu_a | alu_b;
      ALU_AND:    alu_result = alu_a & alu_b;
      ALU_PASS_B: alu_result = alu_b;
      default:    alu_result = '0;
    endcase
  end

  // --------------------
  // Branch condition
  always_comb begin
    case (funct3)
      F3_BEQ:  taken = (rs1_data == rs2_data);
      F3_BNE:  taken = (rs1_data != rs2_data);
      F3_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
      F3_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      F3_BLTU: taken = (rs1_data < rs2_data);
      F3_BGEU: taken = (rs1_data >= rs2_data);
      default: taken = 1'b0;
    endcase
  end

  // JALR target comes from the ALU sum with bit 0 cleared
  assign target   = is_jalr ? {alu_result[XLEN-1:1], 1'b0} : pc + imm;
  assign pc_plus4 = pc + 32'd4;
  assign next_pc  = (is_jump || (is_branch && taken)) ? target : pc_plus4;

endmodule

// ==== hw/rv_isa_pkg.sv ====
package rv_isa_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [3:0]      strb_t;

  // --------------------
  // Major opcodes
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // --------------------
  // funct3 encodings
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam logic [2:0] F3_LB  = 3'b000;
  localparam logic [2:0] F3_LH  = 3'b001;
  localparam logic [2:0] F3_LW  = 3'b010;
  localparam logic [2:0] F3_LBU = 3'b100;
  localparam logic [2:0] F3_LHU = 3'b101;

  localparam logic [2:0] F3_SB = 3'b000;
  localparam logic [2:0] F3_SH = 3'b001;
  localparam logic [2:0] F3_SW = 3'b010;

  // SUB and SRA share ADD and SRL, told apart by funct7 bit 5
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SRL  = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // --------------------
  // Instruction formats
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // B format uses the same field layout
  typedef struct packed {
    logic [6:0] imm_hi;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  // J format uses the same field layout
  typedef struct packed {
    logic [19:0] imm;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    u_fmt_t u;
  } instr_t;

  localparam word_t I_NOP    = 32'h0000_0013;
  localparam word_t I_EBREAK = 32'h0010_0073;

endpackage

// ==== hw/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile
  import rv_isa_pkg::*;
(
  input  logic      clk,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  output word_t     rs1_data,
  output word_t     rs2_data,
  input  logic      we,
  input  reg_addr_t rd_addr,
  input  word_t     rd_data
);

  word_t regs [32];

  // x0 is never written, so entry 0 is never read either
  always_ff @(posedge clk) begin
    if (we && (rd_addr != '0)) begin
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== hw/rv_result.sv ====
`timescale 1ns/1ps

module rv_result
  import rv_isa_pkg::*;
  import rv_core_pkg::*;
(
  input  word_t      alu_result,
  input  word_t      rs2_data,
  input  word_t      dmem_rdata,
  input  logic [2:0] funct3,
  input  logic       mem_write,
  input  res_sel_t   res_sel,
  input  word_t      pc_plus4,
  output word_t      dmem_addr,
  output word_t      dmem_wdata,
  output strb_t      dmem_wstrb,
  output word_t      rd_data
);

  logic [1:0] byte_off;
  word_t      lane_data;
  word_t      load_data;

  assign dmem_addr = alu_result;
  assign byte_off  = alu_result[1:0];

  // --------------------
  // Store lanes
  always_comb begin
    case (funct3)
      F3_SB: begin
        dmem_wdata = {4{rs2_data[7:0]}};
        dmem_wstrb = strb_t'(4'b0001 << byte_off);
      end
      F3_SH: begin
        dmem_wdata = {2{rs2_data[15:0]}};
        dmem_wstrb = byte_off[1] ? 4'b1100 : 4'b0011;
      end
      F3_SW: begin
        dmem_wdata = rs2_data;
        dmem_wstrb = 4'b1111;
      end
      default: begin
        dmem_wdata = rs2_data;
        dmem_wstrb = 4'b0000;
      end
    endcase
    if (!mem_write) begin
      dmem_wstrb = 4'b0000;
    end
  end

  // --------------------
  // Load extraction, addressed lane moved down to bit 0
  assign lane_data = dmem_rdata >> {byte_off, 3'b000};

  always_comb begin
    case (funct3)
      F3_LB:   load_data = {{24{lane_data[7]}}, lane_data[7:0]};
      F3_LH:   load_data = {{16{lane_data[15]}}, lane_data[15:0]};
      F3_LW:   load_data = dmem_rdata;
      F3_LBU:  load_data = {24'b0, lane_data[7:0]};
      F3_LHU:  load_data = {16'b0, lane_data[15:0]};
      default: load_data = '0;
    endcase
  end

  always_comb begin
    case (res_sel)
      RES_LOAD: rd_data = load_data;
      RES_PC4:  rd_data = pc_plus4;
      default:  rd_data = alu_result;
    endcase
  end

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module tb_rv_core -f vlog.f -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== testbench/tb_rv_model.svh ====
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// --------------------
// Instruction encoders
function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2, input reg_addr_t rs1,
                                input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] op);
  return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1, input logic [2:0] f3,
                                input reg_addr_t rd, input logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2, input reg_addr_t rs1,
                                input logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
endfunction

function automatic word_t enc_b(input logic [12:0] imm, input reg_addr_t rs2, input reg_addr_t rs1,
                                input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
endfunction

function automatic word_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
endfunction

// --------------------
// Reference ALU and instruction step
function automatic word_t alu_ref(input logic [2:0] f3, input logic alt, input word_t x,
                                  input word_t y);
  case (f3)
    F3_ADD:  return alt ? x - y : x + y;
    F3_SLL:  return x << y[4:0];
    F3_SLT:  return {31'b0, $signed(x) < $signed(y)};
    F3_SLTU: return {31'b0, x < y};
    F3_XOR:  return x ^ y;
    F3_SRL:  return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
    F3_OR:   return x | y;
    default: return x & y;
  endcase
endfunction

function automatic void rv_ref_step(input instr_t ins, output logic st_we, output word_t st_addr,
                                   output word_t st_data, output strb_t st_strb,
                                   output logic brk);
  word_t      w;
  word_t      a;
  word_t      b;
  word_t      imm;
  word_t      val;
  word_t      addr;
  word_t      lane;
  word_t      npc;
  logic [2:0] f3;
  logic       wr;
  logic       taken;
  w = ins;
  f3 = w[14:12];
  a = m_regs[w[19:15]];
  b = m_regs[w[24:20]];
  imm = {{20{w[31]}}, w[31:20]};
  npc = m_pc + 32'd4;
  val = '0;
  wr = 1'b0;
  taken = 1'b0;
  st_we = 1'b0;
  st_addr = '0;
  st_data = '0;
  st_strb = '0;
  brk = 1'b0;
  case (w[6:0])
    OP_LUI: begin
      val = {w[31:12], 12'b0};
      wr = 1'b1;
    end
    OP_AUIPC: begin
      val = m_pc + {w[31:12], 12'b0};
      wr = 1'b1;
    end
    OP_JAL: begin
      val = m_pc + 32'd4;
      wr = 1'b1;
      npc = m_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    end
    OP_JALR: begin
      val = m_pc + 32'd4;
      wr = 1'b1;
      npc = (a + imm) & ~32'd1;
    end
    OP_BRANCH: begin
      case (f3)
        F3_BEQ:  taken = (a == b);
        F3_BNE:  taken = (a != b);
        F3_BLT:  taken = ($signed(a) < $signed(b));
        F3_BGE:  taken = ($signed(a) >= $signed(b));
        F3_BLTU: taken = (a < b);
        default: taken = (a >= b);
      endcase
      if (taken) begin
        npc = m_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      end
    end
    OP_LOAD: begin
      addr = a + imm;
      lane = m_dmem[addr[9:2]] >> {addr[1:0], 3'b000};
      wr = 1'b1;
      case (f3)
        F3_LB:   val = {{24{lane[7]}}, lane[7:0]};
        F3_LH:   val = {{16{lane[15]}}, lane[15:0]};
        F3_LBU:  val = {24'b0, lane[7:0]};
        F3_LHU:  val = {16'b0, lane[15:0]};
        default: val = m_dmem[addr[9:2]];
      endcase
    end
    OP_STORE: begin
      addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
      st_we = 1'b1;
      st_addr = addr;
      // One strobe bit per byte lane that the access covers
      case (f3)
        F3_SB: begin
          st_data = {4{b[7:0]}};
          st_strb[addr[1:0]] = 1'b1;
        end
        F3_SH: begin
          st_data = {2{b[15:0]}};
          st_strb[{addr[1], 1'b0} +: 2] = 2'b11;
        end
        default: begin
          st_data = b;
          st_strb = 4'b1111;
        end
      endcase
      for (int k = 0; k < 4; k++) begin
        if (st_strb[k]) begin
          m_dmem[addr[9:2]][8*k +: 8] = st_data[8*k +: 8];
        end
      end
    end
    OP_IMM: begin
      val = alu_ref(f3, (f3 == F3_SRL) && w[30], a, imm);
      wr = 1'b1;
    end
    OP_REG: begin
      val = alu_ref(f3, w[30], a, b);
      wr = 1'b1;
    end
    OP_SYSTEM: brk = (w == I_EBREAK);
    default: wr = 1'b0;
  endcase
  if (wr && (w[11:7] != 5'd0)) begin
    m_regs[w[11:7]] = val;
  end
  m_pc = npc;
endfunction

// --------------------
// Program generation
function automatic word_t rnd();
  return $random(seed);
endfunction

function automatic reg_addr_t rand_reg();
  word_t tmp;
  tmp = $unsigned(rnd()) % 30;
  return reg_addr_t'(tmp + 1);
endfunction

task automatic emit(input word_t w);
  imem[prog_len[9:0]] = w;
  prog_len++;
endtask

// Dump a register to the next slot above 0x100
task automatic save_reg(input reg_addr_t r);
  emit(enc_s({4'b0001, slot, 2'b00}, r, 5'd31, F3_SW));
  slot++;
endtask

task automatic gen_setup();
  word_t w;
  for (int r = 1; r < 31; r++) begin
    w = rnd();
    emit({w[31:12], reg_addr_t'(r), OP_LUI});
    emit(enc_i(w[11:0], reg_addr_t'(r), F3_ADD, reg_addr_t'(r), OP_IMM));
  end
  // x31 stays the data base pointer
  emit(enc_i(12'h100, 5'd0, F3_ADD, 5'd31, OP_IMM));
endtask

task automatic gen_alu(input int n);
  word_t       r;
  logic [2:0]  f3;
  logic [11:0] imm;
  logic        alt;
  reg_addr_t   rd;
  for (int i = 0; i < n; i++) begin
    r = rnd();
    f3 = r[2:0];
    rd = rand_reg();
    alt = r[3] && ((f3 == F3_ADD) || (f3 == F3_SRL));
    if (r[4]) begin
      emit(enc_r(alt ? 7'h20 : 7'h00, rand_reg(), rand_reg(), f3, rd, OP_REG));
    end else begin
      imm = r[31:20];
      if (f3 == F3_SLL) imm = {7'h00, r[24:20]};
      if (f3 == F3_SRL) imm = {r[3] ? 7'h20 : 7'h00, r[24:20]};
      emit(enc_i(imm, rand_reg(), f3, rd, OP_IMM));
    end
    save_reg(rd);
  end
endtask

task automatic gen_mem(input int n);
  word_t       r;
  logic [11:0] off;
  logic [11:0] ld_off;
  logic [2:0]  f3;
  reg_addr_t   rd;
  for (int i = 0; i < n; i++) begin
    r = rnd();
    rd = rand_reg();
    emit({r[31:12], rd, OP_LUI});
    save_reg(rd);
    rd = rand_reg();
    emit({r[19:0], rd, OP_AUIPC});
    save_reg(rd);
    // Offsets cycle through every legal byte position
    off = {4'b0010, r[5:0], 2'b00};
    case (i % 3)
      0: begin
        f3 = F3_SB;
        off[1:0] = i[1:0];
      end
      1: begin
        f3 = F3_SH;
        off[1] = i[0];
      end
      default: f3 = F3_SW;
    endcase
    emit(enc_s(off, rand_reg(), 5'd31, f3));
    case (i % 5)
      0: f3 = F3_LB;
      1: f3 = F3_LH;
      2: f3 = F3_LW;
      3: f3 = F3_LBU;
      default: f3 = F3_LHU;
    endcase
    ld_off = {off[11:2], 2'b00};
    if ((f3 == F3_LB) || (f3 == F3_LBU)) ld_off = {off[11:2], i[3:2]};
    if ((f3 == F3_LH) || (f3 == F3_LHU)) ld_off = {off[11:2], i[2], 1'b0};
    rd = rand_reg();
    emit(enc_i(ld_off, 5'd31, f3, rd, OP_LOAD));
    save_reg(rd);
  end
endtask

task automatic gen_branch(input int n);
  word_t      r;
  logic [2:0] f3;
  reg_addr_t  rs1;
  reg_addr_t  rd;
  reg_addr_t  rt;
  for (int i = 0; i < n; i++) begin
    r = rnd();
    rs1 = rand_reg();
    case (i % 6)
      0: f3 = F3_BEQ;
      1: f3 = F3_BNE;
      2: f3 = F3_BLT;
      3: f3 = F3_BGE;
      4: f3 = F3_BLTU;
      default: f3 = F3_BGEU;
    endcase
    // Skipped ADDI shows whether the branch was taken
    rd = rand_reg();
    emit(enc_b(13'd8, r[0] ? rs1 : rand_reg(), rs1, f3));
    emit(enc_i(12'd1, rd, F3_ADD, rd, OP_IMM));
    save_reg(rd);
    rd = rand_reg();
    emit(enc_j(21'd8, rd));
    emit(enc_i(12'd1, rd, F3_ADD, rd, OP_IMM));
    save_reg(rd);
    rt = rand_reg();
    rd = rand_reg();
    emit({20'b0, rt, OP_AUIPC});
    emit(enc_i(12'd12, rt, 3'b000, rd, OP_JALR));
    emit(enc_i(12'd1, rd, F3_ADD, rd, OP_IMM));
    save_reg(rd);
  end
endtask

task automatic gen_tail();
  word_t r;
  r = rnd();
  emit(enc_i(r[11:0], rand_reg(), F3_ADD, 5'd0, OP_IMM));
  save_reg(5'd0);
  emit(I_EBREAK);
  emit(enc_j(21'd0, 5'd0));
endtask

`endif

// ==== testbench/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core
  import rv_isa_pkg::*;
();

  logic  clk = 1'b0;
  logic  reset;
  word_t imem_addr;
  word_t imem_data;
  word_t dmem_addr;
  word_t dmem_rdata;
  logic  dmem_we;
  word_t dmem_wdata;
  strb_t dmem_wstrb;
  logic  ebreak;

  word_t      imem [1024];
  word_t      dmem [256];
  word_t      m_dmem [256];
  word_t      m_regs [32];
  word_t      m_pc;
  integer     seed = 32'h426c;
  int         prog_len = 0;
  logic [5:0] slot = '0;
  logic       gen_done = 1'b0;
  int         checks = 0;
  int         errors = 0;

  `include "tb_rv_model.svh"

  rv_core u_rv_core (
    .clk        (clk),
    .reset      (reset),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_addr  (dmem_addr),
    .dmem_rdata (dmem_rdata),
    .dmem_we    (dmem_we),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .ebreak     (ebreak)
  );

  // --------------------
  // Memories
  assign imem_data  = imem[imem_addr[11:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (dmem_we) begin
      for (int k = 0; k < 4; k++) begin
        if (dmem_wstrb[k]) dmem[dmem_addr[9:2]][8*k +: 8] <= dmem_wdata[8*k +: 8];
      end
    end
  end

  initial begin
    forever #20 clk = ~clk;
  end

  // --------------------
  // Check tasks
  task automatic check_addr(input word_t exp, input word_t got, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s expected %h, got %h", $time, what, exp, got);
    end
  endtask

  task automatic check_store(input word_t addr, input word_t data, input strb_t strb);
    checks++;
    if ((dmem_addr !== addr) || (dmem_wdata !== data) || (dmem_wstrb !== strb)) begin
      errors++;
      $display("[ERROR] %0t: store expected %h/%h/%b, got %h/%h/%b", $time,
               addr, data, strb, dmem_addr, dmem_wdata, dmem_wstrb);
    end
  endtask

  task automatic check_flag(input logic exp, input logic got, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s expected %b, got %b", $time, what, exp, got);
    end
  endtask

  // --------------------
  // Stimulus
  initial begin
    word_t first_word;
    reset = 1'b1;
    for (int i = 0; i < 256; i++) begin
      dmem[i[7:0]] = 32'h9e37_79b9 ^ (32'h0101_0003 * i);
      m_dmem[i[7:0]] = 32'h9e37_79b9 ^ (32'h0101_0003 * i);
    end
    for (int i = 0; i < 32; i++) begin
      m_regs[i[4:0]] = '0;
    end
    m_pc = '0;
    gen_setup();
    gen_alu(60);
    gen_mem(30);
    gen_branch(24);
    gen_tail();
    gen_done = 1'b1;
    // Address 0 holds a store, then an ebreak, while the core sits in reset
    first_word = imem[0];
    imem[0] = enc_s(12'h000, 5'd0, 5'd0, F3_SW);
    repeat (2) @(posedge clk);
    #2 imem[0] = I_EBREAK;
    repeat (2) @(posedge clk);
    #2;
    imem[0] = first_word;
    reset = 1'b0;
  end

  // Compare against the model at the falling edge
  initial begin
    logic  done;
    logic  exp_we;
    logic  exp_brk;
    word_t exp_addr;
    word_t exp_data;
    strb_t exp_strb;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (reset) begin
        check_flag(1'b0, dmem_we, "dmem_we in reset");
        check_flag(1'b0, ebreak, "ebreak in reset");
      end else begin
        check_addr(m_pc, imem_addr, "fetch address");
        rv_ref_step(imem[m_pc[11:2]], exp_we, exp_addr, exp_data, exp_strb, exp_brk);
        check_flag(exp_we, dmem_we, "dmem_we");
        if (exp_we) check_store(exp_addr, exp_data, exp_strb);
        check_flag(exp_brk, ebreak, "ebreak");
        done = exp_brk;
      end
    end
    @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    int limit;
    wait (gen_done);
    limit = (prog_len + 4 + 20) * 40;
    #(limit);
    $display("Timeout: the core never fetched the final ebreak");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+testbench
hw/rv_isa_pkg.sv
hw/rv_core_pkg.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_result.sv
hw/rv_core.sv
testbench/tb_rv_core.sv
